/* src/pc_config_pkg.sv */
`default_nettype none

package pc_config_pkg;

  //////////////////////////////
  // word layout
  //////////////////////////////

  // width of one config register and of one channel piece
  localparam int conf_width = 16;

  // odd multiplier for the register reset pattern
  localparam int reg_reset_mult = 'h9e37;

  // host word as seen by the fpga side
  // same field split for register and channel words
  typedef struct packed {
    logic                  fpga_or_bd;
    logic [5:0]            array_id;
    logic [3:0]            unused;
    logic [conf_width-1:0] conf_data;
  } pc_word_t;

  // chip-bound view of the low 26 bits
  typedef struct packed {
    logic [5:0]  leaf_code;
    logic [19:0] payload;
  } bd_word_t;

  // routing class of one host word
  typedef enum logic [1:0] {
    bd_word,
    reg_word,
    chan_word
  } word_kind_e;

  //////////////////////////////
  // register reset values
  //////////////////////////////

  // index times an odd constant, low 16 bits kept
  function automatic logic [conf_width-1:0] reg_reset_value(input int idx);
    logic [31:0] product;
    product = idx * reg_reset_mult;
    return product[conf_width-1:0];
  endfunction

endpackage

`default_nettype wire

/* src/pc_word_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_word_parser #(
  parameter int nreg  = 33,
  parameter int nchan = 2
) (
  input  wire logic                                           clk,
  input  wire logic                                           reset,
  // host side
  input  wire pc_config_pkg::pc_word_t                        pc_word,
  input  wire logic                                           pc_valid,
  output logic                                                pc_ack,
  // register array
  output logic [nreg-1:0][pc_config_pkg::conf_width-1:0]      conf_reg,
  // channel pieces
  output logic [nchan-1:0]                                    chan_in_valid,
  input  wire logic [nchan-1:0]                               chan_in_ack,
  output logic [pc_config_pkg::conf_width-1:0]                chan_piece,
  // chip-bound words
  output logic                                                bd_in_valid,
  input  wire logic                                           bd_in_ack,
  output pc_config_pkg::bd_word_t                             bd_in_word
);

  // at least one bit even for a single channel
  localparam int chan_bits = (nchan > 1) ? $clog2(nchan) : 1;

  pc_config_pkg::word_kind_e kind;
  logic [chan_bits-1:0]      chan_idx;
  logic                      reg_write;

  //////////////////////////////
  // classification
  //////////////////////////////

  // top bit clear means chip-bound
  // both high id bits set means channel
  always_comb begin
    if (!pc_word.fpga_or_bd) begin
      kind = pc_config_pkg::bd_word;
    end else if (pc_word.array_id[5] && pc_word.array_id[4]) begin
      kind = pc_config_pkg::chan_word;
    end else begin
      kind = pc_config_pkg::reg_word;
    end
  end

  // channel select wraps on the channel count
  assign chan_idx = chan_bits'(int'(pc_word.array_id) % nchan);

  //////////////////////////////
  // register array
  //////////////////////////////

  // ids at or above nreg are acked but never written
  assign reg_write = pc_valid && (kind == pc_config_pkg::reg_word) &&
                     (int'(pc_word.array_id) < nreg);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < nreg; i++) begin
        conf_reg[i] <= pc_config_pkg::reg_reset_value(i);
      end
    end else if (reg_write) begin
      for (int i = 0; i < nreg; i++) begin
        if (i == int'(pc_word.array_id)) begin
          conf_reg[i] <= pc_word.conf_data;
        end
      end
    end
  end

  //////////////////////////////
  // downstream valids
  //////////////////////////////

  // one-hot valid toward the selected deserializer
  always_comb begin
    for (int i = 0; i < nchan; i++) begin
      chan_in_valid[i] = pc_valid && (kind == pc_config_pkg::chan_word) &&
                         (chan_idx == chan_bits'(i));
    end
  end

  assign chan_piece = pc_word.conf_data;

  // chip-bound words take the low 26 bits unchanged
  assign bd_in_valid = pc_valid && (kind == pc_config_pkg::bd_word);
  assign bd_in_word  = pc_config_pkg::bd_word_t'(pc_word[25:0]);

  // ack back to host
  // registers always take the word, others follow their target
  always_comb begin
    pc_ack = 1'b0;
    if (pc_valid) begin
      case (kind)
        pc_config_pkg::bd_word:   pc_ack = bd_in_ack;
        pc_config_pkg::reg_word:  pc_ack = 1'b1;
        pc_config_pkg::chan_word: pc_ack = chan_in_ack[chan_idx];
        default:                  pc_ack = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/conf_chan_deser.sv */
`timescale 1ns/100ps
`default_nettype none

module conf_chan_deser #(
  parameter int chan_pieces = 2
) (
  input  wire logic                                          clk,
  input  wire logic                                          reset,
  // piece input from the parser
  input  wire logic                                          in_valid,
  output logic                                               in_ack,
  input  wire logic [pc_config_pkg::conf_width-1:0]          in_piece,
  // assembled channel value
  output logic                                               out_valid,
  input  wire logic                                          out_ack,
  output logic [chan_pieces*pc_config_pkg::conf_width-1:0]   out_data
);

  localparam int piece_w   = pc_config_pkg::conf_width;
  localparam int data_w    = chan_pieces * piece_w;
  // counter keeps one bit for a single piece
  localparam int cnt_bits  = (chan_pieces > 1) ? $clog2(chan_pieces) : 1;

  typedef enum logic {
    collecting,
    full
  } deser_state_e;

  deser_state_e         state;
  logic [cnt_bits-1:0]  piece_cnt;
  logic [data_w-1:0]    shift_buf;
  logic                 take_piece;
  logic                 last_piece;

  //////////////////////////////
  // handshakes
  //////////////////////////////

  // input blocked while a full value waits
  assign in_ack     = (state == collecting);
  assign out_valid  = (state == full);
  assign out_data   = shift_buf;

  assign take_piece = in_valid && in_ack;
  assign last_piece = (piece_cnt == cnt_bits'(chan_pieces - 1));

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= collecting;
      piece_cnt <= '0;
    end else begin
      case (state)
        collecting: begin
          if (take_piece) begin
            if (last_piece) begin
              state     <= full;
              piece_cnt <= '0;
            end else begin
              piece_cnt <= piece_cnt + 1'b1;
            end
          end
        end
        full: begin
          // back to collecting once the value is taken
          if (out_ack) begin
            state <= collecting;
          end
        end
        default: state <= collecting;
      endcase
    end
  end

  // new pieces enter at the top and move down
  // so the first piece ends up in the low bits
  always_ff @(posedge clk) begin
    if (take_piece) begin
      shift_buf <= (shift_buf >> piece_w) |
                   (data_w'(in_piece) << ((chan_pieces - 1) * piece_w));
    end
  end

endmodule

`default_nettype wire

/* src/bd_word_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module bd_word_queue #(
  parameter int bd_depth = 4
) (
  input  wire logic                     clk,
  input  wire logic                     reset,
  // write side
  input  wire logic                     in_valid,
  output logic                          in_ack,
  input  wire pc_config_pkg::bd_word_t  in_word,
  // read side
  output logic                          out_valid,
  input  wire logic                     out_ack,
  output pc_config_pkg::bd_word_t       out_word
);

  localparam int ptr_bits = (bd_depth > 1) ? $clog2(bd_depth) : 1;
  localparam int cnt_bits = $clog2(bd_depth + 1);

  pc_config_pkg::bd_word_t mem [bd_depth];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push;
  logic                pop;

  //////////////////////////////
  // status
  //////////////////////////////

  // full queue stalls the host through in_ack
  assign in_ack    = (count != cnt_bits'(bd_depth));
  assign out_valid = (count != '0);
  // oldest entry shown on the output
  assign out_word  = mem[rd_ptr];

  assign push = in_valid && in_ack;
  assign pop  = out_valid && out_ack;

  //////////////////////////////
  // pointers and count
  //////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // wrap by compare, depth need not be a power of two
        wr_ptr <= (wr_ptr == ptr_bits'(bd_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_bits'(bd_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_word;
    end
  end

endmodule

`default_nettype wire

/* src/pc_config_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_config_top #(
  parameter int nreg        = 33,
  parameter int nchan       = 2,
  parameter int chan_pieces = 2,
  parameter int bd_depth    = 4
) (
  input  wire logic                                                          clk,
  input  wire logic                                                          reset,
  // host link
  input  wire pc_config_pkg::pc_word_t                                       pc_word,
  input  wire logic                                                          pc_valid,
  output logic                                                               pc_ack,
  // config registers
  output logic [nreg-1:0][pc_config_pkg::conf_width-1:0]                     conf_reg,
  // config channels
  output logic [nchan-1:0]                                                   chan_valid,
  input  wire logic [nchan-1:0]                                              chan_ack,
  output logic [nchan-1:0][chan_pieces*pc_config_pkg::conf_width-1:0]        chan_data,
  // toward the chip
  output logic                                                               bd_valid,
  input  wire logic                                                          bd_ack,
  output pc_config_pkg::bd_word_t                                            bd_word
);

  // parser to deserializers
  logic [nchan-1:0]                      chan_in_valid;
  logic [nchan-1:0]                      chan_in_ack;
  logic [pc_config_pkg::conf_width-1:0]  chan_piece;

  // parser to queue
  logic                                  bd_in_valid;
  logic                                  bd_in_ack;
  pc_config_pkg::bd_word_t               bd_in_word;

  //////////////////////////////
  // word decode
  //////////////////////////////

  pc_word_parser #(
    .nreg  (nreg),
    .nchan (nchan)
  ) u_pc_word_parser (
    .clk           (clk),
    .reset         (reset),
    .pc_word       (pc_word),
    .pc_valid      (pc_valid),
    .pc_ack        (pc_ack),
    .conf_reg      (conf_reg),
    .chan_in_valid (chan_in_valid),
    .chan_in_ack   (chan_in_ack),
    .chan_piece    (chan_piece),
    .bd_in_valid   (bd_in_valid),
    .bd_in_ack     (bd_in_ack),
    .bd_in_word    (bd_in_word)
  );

  // chip-bound buffering
  bd_word_queue #(
    .bd_depth (bd_depth)
  ) u_bd_word_queue (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (bd_in_valid),
    .in_ack    (bd_in_ack),
    .in_word   (bd_in_word),
    .out_valid (bd_valid),
    .out_ack   (bd_ack),
    .out_word  (bd_word)
  );

  // one deserializer per channel, all share the piece bus
  for (genvar c = 0; c < nchan; c++) begin : g_chan
    conf_chan_deser #(
      .chan_pieces (chan_pieces)
    ) u_conf_chan_deser (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (chan_in_valid[c]),
      .in_ack    (chan_in_ack[c]),
      .in_piece  (chan_piece),
      .out_valid (chan_valid[c]),
      .out_ack   (chan_ack[c]),
      .out_data  (chan_data[c])
    );
  end

endmodule

`default_nettype wire

/* test/pc_config_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_config_properties #(
  parameter int nchan  = 2,
  parameter int chan_w = 32
) (
  input wire logic                          clk,
  input wire logic                          reset,
  input wire logic                          pc_valid,
  input wire logic                          pc_ack,
  input wire logic [nchan-1:0]              chan_valid,
  input wire logic [nchan-1:0]              chan_ack,
  input wire logic [nchan-1:0][chan_w-1:0]  chan_data,
  input wire logic                          bd_valid,
  input wire logic                          bd_ack,
  input wire pc_config_pkg::bd_word_t       bd_word
);

  // failed assertions so far, read by the testbench at the end
  int fail_count = 0;

  //////////////////////////////
  // host side
  //////////////////////////////

  // ack only answers a presented word
  a_ack_needs_valid: assert property (
    @(posedge clk) disable iff (reset) pc_ack |-> pc_valid
  ) else begin
    fail_count = fail_count + 1;
    $error("pc_ack high without pc_valid");
  end

  //////////////////////////////
  // output sides
  //////////////////////////////

  // channel value held until taken
  for (genvar c = 0; c < nchan; c++) begin : g_chan
    a_chan_hold: assert property (
      @(posedge clk) disable iff (reset)
      chan_valid[c] && !chan_ack[c] |=> chan_valid[c] && $stable(chan_data[c])
    ) else begin
      fail_count = fail_count + 1;
      $error("chan_valid or chan_data changed before chan_ack");
    end
  end

  // oldest chip word held until taken
  a_bd_hold: assert property (
    @(posedge clk) disable iff (reset)
    bd_valid && !bd_ack |=> bd_valid && $stable(bd_word)
  ) else begin
    fail_count = fail_count + 1;
    $error("bd_valid or bd_word changed before bd_ack");
  end

endmodule

bind pc_config_top pc_config_properties #(
  .nchan  (nchan),
  .chan_w (chan_pieces * pc_config_pkg::conf_width)
) u_pc_config_properties (
  .clk        (clk),
  .reset      (reset),
  .pc_valid   (pc_valid),
  .pc_ack     (pc_ack),
  .chan_valid (chan_valid),
  .chan_ack   (chan_ack),
  .chan_data  (chan_data),
  .bd_valid   (bd_valid),
  .bd_ack     (bd_ack),
  .bd_word    (bd_word)
);

`default_nettype wire

/* test/pc_config_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_config_tb;

  localparam int nreg        = 33;
  localparam int nchan       = 2;
  localparam int chan_pieces = 2;
  localparam int bd_depth    = 4;
  localparam int conf_w      = pc_config_pkg::conf_width;
  localparam int chan_w      = chan_pieces * conf_w;
  localparam int n_words     = 2000;
  localparam int clk_period  = 100;
  localparam int seed        = 3509;
  // cycles allowed for the outputs to empty after the last word
  localparam int drain_limit = 500;

  logic                          clk;
  logic                          reset;
  pc_config_pkg::pc_word_t       pc_word;
  logic                          pc_valid;
  logic                          pc_ack;
  logic [nreg-1:0][conf_w-1:0]   conf_reg;
  logic [nchan-1:0]              chan_valid;
  logic [nchan-1:0]              chan_ack;
  logic [nchan-1:0][chan_w-1:0]  chan_data;
  logic                          bd_valid;
  logic                          bd_ack;
  pc_config_pkg::bd_word_t       bd_word;

  // reference model state
  logic [conf_w-1:0]             exp_reg [nreg];
  logic [chan_w-1:0]             exp_chan [nchan][$];
  logic [chan_w-1:0]             partial [nchan];
  int                            piece_cnt [nchan];
  pc_config_pkg::bd_word_t       exp_bd [$];
  logic                          checking;

  pc_config_top u_pc_config_top (
    .clk        (clk),
    .reset      (reset),
    .pc_word    (pc_word),
    .pc_valid   (pc_valid),
    .pc_ack     (pc_ack),
    .conf_reg   (conf_reg),
    .chan_valid (chan_valid),
    .chan_ack   (chan_ack),
    .chan_data  (chan_data),
    .bd_valid   (bd_valid),
    .bd_ack     (bd_ack),
    .bd_word    (bd_word)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s (at %0t ns)", why, $time);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  // index times the odd constant, low 16 bits
  function automatic logic [conf_w-1:0] reset_pattern(input int idx);
    logic [31:0] product;
    product = 32'(idx) * 32'(pc_config_pkg::reg_reset_mult);
    return product[conf_w-1:0];
  endfunction

  // top bit picks the chip, then the two high id bits pick a channel
  function automatic pc_config_pkg::word_kind_e classify(input pc_config_pkg::pc_word_t w);
    pc_config_pkg::word_kind_e k;
    if (w.fpga_or_bd == 1'b0) begin
      k = pc_config_pkg::bd_word;
    end else if (w.array_id[5:4] == 2'b11) begin
      k = pc_config_pkg::chan_word;
    end else begin
      k = pc_config_pkg::reg_word;
    end
    return k;
  endfunction

  // roughly 40% chip, 30% register (ids 0..47), 30% channel
  function automatic pc_config_pkg::pc_word_t random_word();
    pc_config_pkg::pc_word_t w;
    int pick;
    pick = $urandom_range(0, 9);
    w = pc_config_pkg::pc_word_t'(27'($urandom));
    if (pick < 4) begin
      w.fpga_or_bd = 1'b0;
    end else if (pick < 7) begin
      w.fpga_or_bd = 1'b1;
      w.array_id   = 6'($urandom_range(0, 47));
    end else begin
      w.fpga_or_bd    = 1'b1;
      w.array_id[5:4] = 2'b11;
    end
    return w;
  endfunction

  function automatic bit model_drained();
    bit empty;
    empty = (exp_bd.size() == 0);
    for (int k = 0; k < nchan; k++) begin
      if (exp_chan[k].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  //////////////////////////////
  // output ack levels
  //////////////////////////////

  // random levels, high about 60% of cycles
  always @(posedge clk) begin
    for (int k = 0; k < nchan; k++) begin
      chan_ack[k] <= ($urandom_range(0, 9) < 6);
    end
    bd_ack <= ($urandom_range(0, 9) < 6);
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // all inputs change through nba, so pre-edge values are read here
  always @(posedge clk) begin : model_monitor
    pc_config_pkg::pc_word_t w;
    pc_config_pkg::bd_word_t bdw;
    int c;
    logic exp_ack;
    if (checking) begin
      // ack for the presented word
      // a queued word per model entry, a waiting channel value blocks its channel
      exp_ack = 1'b0;
      c = int'(pc_word.array_id) % nchan;
      if (pc_valid) begin
        case (classify(pc_word))
          pc_config_pkg::bd_word:   exp_ack = (exp_bd.size() < bd_depth);
          pc_config_pkg::reg_word:  exp_ack = 1'b1;
          pc_config_pkg::chan_word: exp_ack = (exp_chan[c].size() == 0);
          default:                  exp_ack = 1'b0;
        endcase
      end
      compare_value("pc_ack", 64'(pc_ack), 64'(exp_ack));
      // registers show every transfer before this edge
      for (int i = 0; i < nreg; i++) begin
        compare_value($sformatf("conf_reg[%0d]", i), 64'(conf_reg[i]), 64'(exp_reg[i]));
      end
      for (int k = 0; k < nchan; k++) begin
        if (chan_valid[k] && chan_ack[k]) begin
          if (exp_chan[k].size() == 0) begin
            stop_run($sformatf("channel %0d delivered a value that was never sent", k));
          end else begin
            compare_value($sformatf("chan_data[%0d]", k), 64'(chan_data[k]),
                          64'(exp_chan[k].pop_front()));
          end
        end
      end
      if (bd_valid && bd_ack) begin
        if (exp_bd.size() == 0) begin
          stop_run("bd_word delivered a word that was never sent");
        end else begin
          compare_value("bd_word", 64'(bd_word), 64'(exp_bd.pop_front()));
        end
      end
      // host transfer
      if (pc_valid && pc_ack) begin
        w = pc_word;
        case (classify(w))
          pc_config_pkg::bd_word: begin
            bdw.leaf_code = w.array_id;
            bdw.payload   = {w.unused, w.conf_data};
            exp_bd.push_back(bdw);
          end
          pc_config_pkg::reg_word: begin
            // ids nreg..47 are dropped
            if (int'(w.array_id) < nreg) begin
              exp_reg[w.array_id] = w.conf_data;
            end
          end
          pc_config_pkg::chan_word: begin
            c = int'(w.array_id) % nchan;
            partial[c] = partial[c] | (chan_w'(w.conf_data) << (piece_cnt[c] * conf_w));
            piece_cnt[c] = piece_cnt[c] + 1;
            if (piece_cnt[c] == chan_pieces) begin
              exp_chan[c].push_back(partial[c]);
              partial[c]   = '0;
              piece_cnt[c] = 0;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    #(n_words * 20 * clk_period);
    stop_run("timeout: the run did not finish in the allowed number of cycles");
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int cycles;
    void'($urandom(seed));
    reset    = 1'b1;
    pc_valid = 1'b0;
    pc_word  = '0;
    chan_ack = '0;
    bd_ack   = 1'b0;
    checking = 1'b0;
    for (int i = 0; i < nreg; i++) begin
      exp_reg[i] = reset_pattern(i);
    end
    for (int k = 0; k < nchan; k++) begin
      partial[k]   = '0;
      piece_cnt[k] = 0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    // state right after reset
    for (int i = 0; i < nreg; i++) begin
      compare_value($sformatf("conf_reg[%0d]", i), 64'(conf_reg[i]), 64'(reset_pattern(i)));
    end
    compare_value("chan_valid", 64'(chan_valid), 64'h0);
    compare_value("bd_valid", 64'(bd_valid), 64'h0);
    checking <= 1'b1;
    for (int n = 0; n < n_words; n++) begin
      // occasional idle cycle between words
      if ($urandom_range(0, 7) == 0) begin
        pc_valid <= 1'b0;
        @(posedge clk);
      end
      pc_word  <= random_word();
      pc_valid <= 1'b1;
      @(posedge clk);
      // word held until the edge that takes it
      while (!pc_ack) @(posedge clk);
    end
    pc_valid <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!model_drained() && cycles < drain_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (model_drained() && u_pc_config_top.u_pc_config_properties.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("expected outputs left over or a handshake assertion failed");
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := pc_config_tb
FILELIST   := verilog.f
OBJDIR     := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verilog.f */
src/pc_config_pkg.sv
src/pc_word_parser.sv
src/conf_chan_deser.sv
src/bd_word_queue.sv
src/pc_config_top.sv
test/pc_config_properties.sv
test/pc_config_tb.sv
